// File: hdl/fc_consts.svh
// Build-time sizes only; the vector length must be a whole number of memory lines
`ifndef FC_CONSTS_SVH
`define FC_CONSTS_SVH

// ========================================================================
// Memory geometry
// ========================================================================
// Byte address width
`define FC_ADDR_W 19
// Bytes in one memory line
`define FC_LINE_BYTES 32
// Lines per data vector, also lines per weight row
`define FC_CHUNKS 4
// Whole vector in bytes
`define FC_VEC_BYTES (`FC_LINE_BYTES * `FC_CHUNKS)

// ========================================================================
// Arithmetic
// ========================================================================
`define FC_ROWS_W 8
`define FC_ACC_W 32
// Scaled ReLU shift, then clip to one byte
`define FC_LOG2_SCALE 8
`define FC_OUT_MAX 255

`endif

// File: hdl/fc_pkg.sv
// Field widths follow fc_consts.svh; cfg must not change while the engine is busy
`default_nettype none

`include "fc_consts.svh"

package fc_pkg;

  // ========================================================================
  // Bytes, addresses and lines
  // ========================================================================
  // Pixel byte, unsigned
  typedef logic [7:0] fc_ubyte_t;
  // Weight byte, named so a select from a packed array stays signed
  typedef logic signed [7:0] fc_sbyte_t;
  typedef logic [`FC_ADDR_W-1:0] fc_addr_t;

  // One memory line, pix view for data and wgt view for weights
  typedef union packed {
    fc_ubyte_t [`FC_LINE_BYTES-1:0] pix;
    fc_sbyte_t [`FC_LINE_BYTES-1:0] wgt;
  } fc_line_u;

  // ========================================================================
  // Run settings and bus structs
  // ========================================================================
  typedef struct packed {
    fc_addr_t              addr_x;
    fc_addr_t              addr_w;
    fc_addr_t              addr_z;
    logic [`FC_ROWS_W-1:0] rows;
  } fc_cfg_t;

  // Full-line read, held until valid
  typedef struct packed {
    logic     req;
    fc_addr_t addr;
  } fc_rd_req_t;

  // Single-cycle answer with the line
  typedef struct packed {
    logic     valid;
    fc_line_u line;
  } fc_rd_rsp_t;

  // Single-byte write, held until ack
  typedef struct packed {
    logic      req;
    fc_addr_t  addr;
    fc_ubyte_t data;
  } fc_wr_req_t;

  // Line pair consumed, last on final chunk of a row
  typedef struct packed {
    logic take;
    logic last;
  } fc_take_t;

endpackage

`default_nettype wire

// File: hdl/fc_ctrl.sv
// Row count of zero is not supported; go is ignored while a run is open
`timescale 1ns/1ns
`default_nettype none

`include "fc_consts.svh"

module fc_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  go,
  input  logic [`FC_ROWS_W-1:0] rows,
  input  fc_pkg::fc_take_t      take,
  input  logic                  row_done,
  output logic                  start,
  output logic                  fetch_en,
  output logic                  busy,
  output logic                  done
);

  typedef enum logic {st_idle, st_run} state_t;

  state_t                state;
  // Rows whose final chunk was taken
  logic [`FC_ROWS_W-1:0] rows_fetched;
  // Rows whose byte was acknowledged
  logic [`FC_ROWS_W-1:0] rows_written;
  logic                  last_fetch;
  logic                  last_write;

  // Final chunk of final row, stop reading after this
  assign last_fetch = take.take && take.last && (rows_fetched == rows - 1'b1);
  assign last_write = row_done && (rows_written == rows - 1'b1);
  assign busy       = (state == st_run);

  // ========================================================================
  // Idle/run FSM
  // ========================================================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= st_idle;
      start        <= 1'b0;
      fetch_en     <= 1'b0;
      done         <= 1'b0;
      rows_fetched <= '0;
      rows_written <= '0;
    end
    else
    begin
      // Pulses by default
      start <= 1'b0;
      done  <= 1'b0;
      case (state)
        st_idle:
        begin
          if (go)
          begin
            state        <= st_run;
            start        <= 1'b1;
            fetch_en     <= 1'b1;
            rows_fetched <= '0;
            rows_written <= '0;
          end
        end
        st_run:
        begin
          if (take.take && take.last)
            rows_fetched <= rows_fetched + 1'b1;
          if (last_fetch)
            fetch_en <= 1'b0;
          if (row_done)
            rows_written <= rows_written + 1'b1;
          // Done on the edge after the last ack
          if (last_write)
          begin
            state <= st_idle;
            done  <= 1'b1;
          end
        end
        default:
          state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/fc_fetch_lane.sv
// One read open at a time and a one-line buffer; base must hold while fetching
`timescale 1ns/1ns
`default_nettype none

`include "fc_consts.svh"

module fc_fetch_lane #(
  parameter bit row_wrap = 1'b0
) (
  input  logic               clk,
  input  logic               rst_n,
  input  fc_pkg::fc_addr_t   base,
  input  logic               start,
  input  logic               fetch_en,
  input  fc_pkg::fc_take_t   take,
  output fc_pkg::fc_rd_req_t req,
  input  fc_pkg::fc_rd_rsp_t rsp,
  output logic               line_valid,
  output fc_pkg::fc_line_u   line
);

  localparam fc_pkg::fc_addr_t line_step = fc_pkg::fc_addr_t'(`FC_LINE_BYTES);

  fc_pkg::fc_addr_t offset;
  logic             req_open;
  logic             full;
  fc_pkg::fc_line_u buf_line;

  // ========================================================================
  // Address offset
  // ========================================================================
  // Moves only on take, so addr stays put while req is open
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      offset <= '0;
    else if (start)
      offset <= '0;
    else if (take.take)
    begin
      // Data lane restarts the vector each row
      if (row_wrap && take.last)
        offset <= '0;
      else
        offset <= offset + line_step;
    end
  end

  // ========================================================================
  // Request slot and line buffer
  // ========================================================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_open <= 1'b0;
      full     <= 1'b0;
    end
    else
    begin
      // Drops in the cycle after valid
      if (rsp.valid)
        req_open <= 1'b0;
      else if (fetch_en && !full && !req_open)
        req_open <= 1'b1;
      if (rsp.valid)
        full <= 1'b1;
      else if (take.take)
        full <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rsp.valid)
      buf_line <= rsp.line;
  end

  always_comb
  begin
    req.req  = req_open;
    req.addr = base + offset;
  end

  assign line_valid = full;
  assign line       = buf_line;

endmodule

`default_nettype wire

// File: hdl/fc_neuron.sv
// Needs both lines of a pair before a take; write address wraps with the row index width
`timescale 1ns/1ns
`default_nettype none

`include "fc_consts.svh"

module fc_neuron (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  input  logic               x_valid,
  input  logic               w_valid,
  input  fc_pkg::fc_line_u   x_line,
  input  fc_pkg::fc_line_u   w_line,
  input  fc_pkg::fc_addr_t   addr_z,
  output fc_pkg::fc_take_t   take,
  output fc_pkg::fc_wr_req_t wr_req,
  input  logic               wr_ack,
  output logic               row_done
);

  localparam int chunk_w = $clog2(`FC_CHUNKS);
  localparam logic [chunk_w-1:0] last_chunk = chunk_w'(`FC_CHUNKS - 1);

  // Chunk within the current row
  logic [chunk_w-1:0]           chunk;
  logic signed [`FC_ACC_W-1:0]  dot;
  logic signed [`FC_ACC_W-1:0]  acc;
  logic signed [`FC_ACC_W-1:0]  acc_next;
  logic signed [`FC_ACC_W-1:0]  shifted;
  fc_pkg::fc_ubyte_t            act_byte;
  // Byte waiting for ack
  logic                         wr_pend;
  fc_pkg::fc_ubyte_t            wr_data;
  logic [`FC_ROWS_W-1:0]        row_idx;

  // ========================================================================
  // Dot product of one line pair
  // ========================================================================
  // Unsigned pixel times signed weight, 17-bit products
  always_comb
  begin
    dot = '0;
    for (int i = 0; i < `FC_LINE_BYTES; i++)
    begin
      dot = dot + $signed({1'b0, x_line.pix[i]}) * w_line.wgt[i];
    end
  end

  assign acc_next = acc + dot;

  // Scaled ReLU
  always_comb
  begin
    shifted = acc_next >>> `FC_LOG2_SCALE;
    if (acc_next[`FC_ACC_W-1])
      act_byte = '0;
    else if (shifted > `FC_OUT_MAX)
      act_byte = 8'(`FC_OUT_MAX);
    else
      act_byte = shifted[7:0];
  end

  // ========================================================================
  // Take, accumulate, write
  // ========================================================================
  // No new pair while a write waits
  always_comb
  begin
    take.take = x_valid && w_valid && !wr_pend;
    take.last = x_valid && w_valid && !wr_pend && (chunk == last_chunk);
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      chunk   <= '0;
      acc     <= '0;
      wr_pend <= 1'b0;
      row_idx <= '0;
    end
    else if (start)
      row_idx <= '0;
    else if (take.take)
    begin
      acc   <= acc_next;
      chunk <= take.last ? '0 : chunk + 1'b1;
      // wr_req rises the cycle after the last chunk
      if (take.last)
        wr_pend <= 1'b1;
    end
    else if (wr_pend && wr_ack)
    begin
      wr_pend <= 1'b0;
      acc     <= '0;
      row_idx <= row_idx + 1'b1;
    end
  end

  // Result byte, held through the write
  always_ff @(posedge clk)
  begin
    if (take.last)
      wr_data <= act_byte;
  end

  always_comb
  begin
    wr_req.req  = wr_pend;
    wr_req.addr = addr_z + fc_pkg::fc_addr_t'(row_idx);
    wr_req.data = wr_data;
  end

  // One pulse per row, in the ack cycle
  assign row_done = wr_pend && wr_ack;

endmodule

`default_nettype wire

// File: hdl/fc_top.sv
// One done pulse per run; cfg must hold while busy and rows must be nonzero
`timescale 1ns/1ns
`default_nettype none

module fc_top (
  input  logic               clk,
  input  logic               rst_n,
  input  fc_pkg::fc_cfg_t    cfg,
  input  logic               go,
  output logic               busy,
  output logic               done,
  output fc_pkg::fc_rd_req_t rd_x_req,
  input  fc_pkg::fc_rd_rsp_t rd_x_rsp,
  output fc_pkg::fc_rd_req_t rd_w_req,
  input  fc_pkg::fc_rd_rsp_t rd_w_rsp,
  output fc_pkg::fc_wr_req_t wr_req,
  input  logic               wr_ack
);

  // ========================================================================
  // Internal wiring
  // ========================================================================
  logic             start;
  logic             fetch_en;
  logic             row_done;
  fc_pkg::fc_take_t take;
  // Lane buffers toward the neuron
  logic             x_valid;
  logic             w_valid;
  fc_pkg::fc_line_u x_line;
  fc_pkg::fc_line_u w_line;

  // Run control
  fc_ctrl u_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .go       (go),
    .rows     (cfg.rows),
    .take     (take),
    .row_done (row_done),
    .start    (start),
    .fetch_en (fetch_en),
    .busy     (busy),
    .done     (done)
  );

  // Data vector lane that rereads the same vector for every row
  fc_fetch_lane #(.row_wrap(1'b1)) u_lane_x (
    .clk        (clk),
    .rst_n      (rst_n),
    .base       (cfg.addr_x),
    .start      (start),
    .fetch_en   (fetch_en),
    .take       (take),
    .req        (rd_x_req),
    .rsp        (rd_x_rsp),
    .line_valid (x_valid),
    .line       (x_line)
  );

  // Weight lane that walks the matrix linearly
  fc_fetch_lane #(.row_wrap(1'b0)) u_lane_w (
    .clk        (clk),
    .rst_n      (rst_n),
    .base       (cfg.addr_w),
    .start      (start),
    .fetch_en   (fetch_en),
    .take       (take),
    .req        (rd_w_req),
    .rsp        (rd_w_rsp),
    .line_valid (w_valid),
    .line       (w_line)
  );

  fc_neuron u_neuron (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .x_valid  (x_valid),
    .w_valid  (w_valid),
    .x_line   (x_line),
    .w_line   (w_line),
    .addr_z   (cfg.addr_z),
    .take     (take),
    .wr_req   (wr_req),
    .wr_ack   (wr_ack),
    .row_done (row_done)
  );

endmodule

`default_nettype wire

// File: tb/fc_mem_model.sv
// Behavioral memory; full-line reads and byte writes, each answered after 1 to 4 cycles
`timescale 1ns/1ns
`default_nettype none

`include "fc_consts.svh"

module fc_mem_model #(
  parameter int seed_init = 24
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  fc_pkg::fc_rd_req_t [1:0] rd_req,
  output fc_pkg::fc_rd_rsp_t [1:0] rd_rsp,
  input  fc_pkg::fc_wr_req_t       wr_req,
  output logic                     wr_ack
);

  logic [7:0] mem [0:(1 << `FC_ADDR_W) - 1];
  integer     seed;
  // Cycles left before each read port answers
  int         rd_wait [2];
  logic [1:0] rd_busy;
  int         wr_wait;
  logic       wr_busy;

  // Background fill where each byte depends on its full address
  initial
  begin
    seed = seed_init;
    for (int a = 0; a < (1 << `FC_ADDR_W); a++)
      mem[a] = a[7:0] ^ a[15:8] ^ {5'b0, a[18:16]};
  end

  // Byte i of a line sits at addr plus i
  function automatic fc_pkg::fc_line_u line_at(input fc_pkg::fc_addr_t addr);
    fc_pkg::fc_line_u l;
    for (int i = 0; i < `FC_LINE_BYTES; i++)
      l.pix[i] = mem[addr + i];
    return l;
  endfunction

  // ========================================================================
  // Read ports with port 0 for data and port 1 for weights
  // ========================================================================
  // Answers change on the falling edge
  always @(negedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_rsp  <= '0;
      rd_busy <= '0;
      rd_wait <= '{0, 0};
    end
    else
    begin
      for (int p = 0; p < 2; p++)
      begin
        rd_rsp[p].valid <= 1'b0;
        if (rd_req[p].req && !rd_busy[p])
        begin
          rd_busy[p] <= 1'b1;
          rd_wait[p] <= int'($unsigned($random(seed)) % 4);
        end
        else if (rd_busy[p] && rd_wait[p] == 0)
        begin
          rd_busy[p]      <= 1'b0;
          rd_rsp[p].valid <= 1'b1;
          rd_rsp[p].line  <= line_at(rd_req[p].addr);
        end
        else if (rd_busy[p])
          rd_wait[p] <= rd_wait[p] - 1;
      end
    end
  end

  // ========================================================================
  // Write port
  // ========================================================================
  always @(negedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ack  <= 1'b0;
      wr_busy <= 1'b0;
      wr_wait <= 0;
    end
    else
    begin
      wr_ack <= 1'b0;
      if (wr_req.req && !wr_busy)
      begin
        wr_busy <= 1'b1;
        wr_wait <= int'($unsigned($random(seed)) % 4);
      end
      else if (wr_busy && wr_wait == 0)
      begin
        wr_busy          <= 1'b0;
        wr_ack           <= 1'b1;
        mem[wr_req.addr] <= wr_req.data;
      end
      else if (wr_busy)
        wr_wait <= wr_wait - 1;
    end
  end

endmodule

`default_nettype wire

// File: tb/fc_tb.sv
// Two runs of 5 and 3 rows from seed 24; the memory model answers with random delays
`timescale 1ns/1ns
`default_nettype none

`include "fc_consts.svh"

module fc_tb;

  // Each row needs its chunks plus the write, each at most about 8 cycles with delays
  localparam int limit_cycles = (5 + 3) * (`FC_CHUNKS + 1) * 8 + 200;

  logic                     clk;
  logic                     rst_n;
  logic                     go;
  logic                     busy;
  logic                     done;
  fc_pkg::fc_cfg_t          cfg;
  fc_pkg::fc_cfg_t          run_cfg;
  fc_pkg::fc_rd_req_t [1:0] rd_req;
  fc_pkg::fc_rd_rsp_t [1:0] rd_rsp;
  fc_pkg::fc_wr_req_t       wr_req;
  logic                     wr_ack;
  integer                   seed;
  int                       data_errors;
  int                       addr_errors;
  int                       hold_errors;
  int                       ctrl_errors;
  int                       done_count;
  int                       x_reads;
  int                       w_reads;
  // Expected writes in order
  fc_pkg::fc_addr_t         exp_addr [$];
  logic [7:0]               exp_data [$];
  // Last cycle's handshake state
  fc_pkg::fc_rd_req_t [1:0] prev_rd;
  logic [1:0]               prev_valid;
  fc_pkg::fc_wr_req_t       prev_wr;
  logic                     prev_ack;

  fc_top i_fc_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .cfg      (cfg),
    .go       (go),
    .busy     (busy),
    .done     (done),
    .rd_x_req (rd_req[0]),
    .rd_x_rsp (rd_rsp[0]),
    .rd_w_req (rd_req[1]),
    .rd_w_rsp (rd_rsp[1]),
    .wr_req   (wr_req),
    .wr_ack   (wr_ack)
  );

  fc_mem_model #(.seed_init(24)) u_mem (
    .clk    (clk),
    .rst_n  (rst_n),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp),
    .wr_req (wr_req),
    .wr_ack (wr_ack)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Watchdog
  initial
  begin
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout after %0d cycles, the engine never finished its runs", limit_cycles);
    $display("TEST FAILED");
    $finish;
  end

  // ========================================================================
  // Memory fill and reference model
  // ========================================================================
  task automatic fill_vector(input fc_pkg::fc_addr_t addr, input bit max_data);
    for (int k = 0; k < `FC_VEC_BYTES; k++)
      u_mem.mem[addr + k] = max_data ? 8'hff : 8'($random(seed));
  endtask

  // Kind 0 random, 1 all negative, 2 all +127
  task automatic fill_weights(input fc_pkg::fc_addr_t addr, input int kind);
    logic [7:0] b;
    for (int k = 0; k < `FC_VEC_BYTES; k++)
    begin
      b = 8'($random(seed));
      if (kind == 1)
        b[7] = 1'b1;
      else if (kind == 2)
        b = 8'h7f;
      u_mem.mem[addr + k] = b;
    end
  endtask

  // Dot product of one row, then negative to 0, shift, clip at the top
  function automatic logic [7:0] expect_byte(input fc_pkg::fc_addr_t ax,
                                             input fc_pkg::fc_addr_t aw);
    longint sum;
    longint scaled;
    sum = 0;
    for (int k = 0; k < `FC_VEC_BYTES; k++)
      sum += longint'(u_mem.mem[ax + k]) * longint'($signed(u_mem.mem[aw + k]));
    if (sum < 0)
      return 8'd0;
    scaled = sum >>> `FC_LOG2_SCALE;
    if (scaled > `FC_OUT_MAX)
      return 8'(`FC_OUT_MAX);
    return 8'(scaled);
  endfunction

  // One control bit that must be low
  task automatic expect_low(input string name, input logic value);
    assert (value === 1'b0) else
    begin
      ctrl_errors++;
      $display("[ERROR] %0t %s expected 0 got %b", $time, name, value);
    end
  endtask

  task automatic check_idle();
    expect_low("busy", busy);
    expect_low("done", done);
    expect_low("rd_x_req.req", rd_req[0].req);
    expect_low("rd_w_req.req", rd_req[1].req);
    expect_low("wr_req.req", wr_req.req);
  endtask

  // Queue expectations, pulse go, wait for done, then check the run totals
  task automatic run_matrix(input fc_pkg::fc_cfg_t c);
    int runs_before;
    runs_before = done_count;
    for (int r = 0; r < int'(c.rows); r++)
    begin
      exp_addr.push_back(c.addr_z + fc_pkg::fc_addr_t'(r));
      exp_data.push_back(expect_byte(c.addr_x,
                                     c.addr_w + fc_pkg::fc_addr_t'(r * `FC_VEC_BYTES)));
    end
    @(negedge clk);
    cfg = c;
    go  = 1'b1;
    @(negedge clk);
    go  = 1'b0;
    while (!done)
      @(negedge clk);
    // Idle cycles to catch a second done or a late write
    repeat (5) @(negedge clk);
    assert (done_count == runs_before + 1 && !busy) else
    begin
      ctrl_errors++;
      $display("Run of %0d rows gave %0d done pulses, busy %b", c.rows,
               done_count - runs_before, busy);
    end
    assert (exp_data.size() == 0) else
    begin
      ctrl_errors++;
      $display("%0d expected writes never arrived", exp_data.size());
    end
    assert (x_reads == c.rows * `FC_CHUNKS && w_reads == c.rows * `FC_CHUNKS) else
    begin
      ctrl_errors++;
      $display("Read counts wrong: data %0d weights %0d", x_reads, w_reads);
    end
  endtask

  // ========================================================================
  // Bus monitors sampled on the rising edge
  // ========================================================================
  always @(posedge clk)
  begin
    fc_pkg::fc_addr_t exp_x;
    fc_pkg::fc_addr_t exp_w;
    exp_x = cfg.addr_x + fc_pkg::fc_addr_t'(`FC_LINE_BYTES * (x_reads % `FC_CHUNKS));
    exp_w = cfg.addr_w + fc_pkg::fc_addr_t'(`FC_LINE_BYTES * w_reads);
    if (go && !busy)
    begin
      x_reads <= 0;
      w_reads <= 0;
    end
    // Data reads wrap per row
    if (rd_req[0].req && rd_rsp[0].valid)
    begin
      assert (rd_req[0].addr == exp_x) else
      begin
        addr_errors++;
        $display("[ERROR] %0t rd_x_req.addr expected %h got %h", $time, exp_x,
                 rd_req[0].addr);
      end
      x_reads <= x_reads + 1;
    end
    // Weight reads walk the matrix and stop at its end
    if (rd_req[1].req && rd_rsp[1].valid)
    begin
      assert (rd_req[1].addr == exp_w && w_reads < cfg.rows * `FC_CHUNKS) else
      begin
        addr_errors++;
        $display("[ERROR] %0t rd_w_req.addr expected %h got %h (read %0d)", $time, exp_w,
                 rd_req[1].addr, w_reads);
      end
      w_reads <= w_reads + 1;
    end
    // Open requests must not move
    for (int p = 0; p < 2; p++)
    begin
      if (prev_rd[p].req && !prev_valid[p])
        assert (rd_req[p] == prev_rd[p]) else
        begin
          hold_errors++;
          $display("[ERROR] %0t rd_req[%0d] expected %h got %h", $time, p, prev_rd[p],
                   rd_req[p]);
        end
    end
    if (prev_wr.req && !prev_ack)
      assert (wr_req == prev_wr) else
      begin
        hold_errors++;
        $display("[ERROR] %0t wr_req expected %h got %h", $time, prev_wr, wr_req);
      end
    prev_rd    <= rd_req;
    prev_valid <= {rd_rsp[1].valid, rd_rsp[0].valid};
    prev_wr    <= wr_req;
    prev_ack   <= wr_ack;
    // Accepted write against the reference
    if (wr_req.req && wr_ack)
    begin
      assert (exp_data.size() > 0) else
      begin
        ctrl_errors++;
        $display("Unexpected write to %h at %0t", wr_req.addr, $time);
      end
      if (exp_data.size() > 0)
      begin
        assert (wr_req.addr == exp_addr[0]) else
        begin
          addr_errors++;
          $display("[ERROR] %0t wr_req.addr expected %h got %h", $time, exp_addr[0],
                   wr_req.addr);
        end
        assert (wr_req.data == exp_data[0]) else
        begin
          data_errors++;
          $display("[ERROR] %0t wr_req.data expected %h got %h", $time, exp_data[0],
                   wr_req.data);
        end
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
      end
    end
    if (done)
    begin
      done_count <= done_count + 1;
      expect_low("busy", busy);
    end
  end

  // ========================================================================
  // Stimulus
  // ========================================================================
  initial
  begin
    rst_n       = 1'b0;
    go          = 1'b0;
    cfg         = '0;
    seed        = 24;
    data_errors = 0;
    addr_errors = 0;
    hold_errors = 0;
    ctrl_errors = 0;
    done_count  = 0;
    x_reads     = 0;
    w_reads     = 0;
    prev_rd     = '0;
    prev_valid  = '0;
    prev_wr     = '0;
    prev_ack    = 1'b0;
    // Fill after the model's background pattern
    @(negedge clk);
    fill_vector(19'h01000, 1'b0);
    for (int r = 0; r < 5; r++)
      fill_weights(19'h02000 + 19'(r * `FC_VEC_BYTES), (r == 3) ? 1 : 0);
    // Second run uses all-255 data with max, negative and random rows
    fill_vector(19'h04020, 1'b1);
    for (int r = 0; r < 3; r++)
      fill_weights(19'h05000 + 19'(r * `FC_VEC_BYTES), (r == 0) ? 2 : ((r == 1) ? 1 : 0));
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    repeat (3)
    begin
      check_idle();
      @(negedge clk);
    end
    run_cfg.addr_x = 19'h01000;
    run_cfg.addr_w = 19'h02000;
    run_cfg.addr_z = 19'h03000;
    run_cfg.rows   = 8'd5;
    run_matrix(run_cfg);
    run_cfg.addr_x = 19'h04020;
    run_cfg.addr_w = 19'h05000;
    run_cfg.addr_z = 19'h060f0;
    run_cfg.rows   = 8'd3;
    run_matrix(run_cfg);
    $display("Errors: data %0d, address %0d, handshake %0d, control %0d", data_errors,
             addr_errors, hold_errors, ctrl_errors);
    if (data_errors + addr_errors + hold_errors + ctrl_errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: fc_engine.f
+incdir+hdl
hdl/fc_pkg.sv
hdl/fc_ctrl.sv
hdl/fc_fetch_lane.sv
hdl/fc_neuron.sv
hdl/fc_top.sv
tb/fc_mem_model.sv
tb/fc_tb.sv

// File: Makefile
# Verilator flow for the FC engine: lint the RTL, run the testbench, clean up

LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f fc_engine.f --top-module fc_top

sim:
	verilator --binary --timing --assert -f fc_engine.f --top-module fc_tb -o fc_sim
	./obj_dir/fc_sim | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
